/* soc_bus_top.f */
src/soc_pkg.sv
src/gpio_regs.sv
src/rng_gen.sv
src/io_bridge.sv
src/scratch_ram.sv
src/bus_fabric.sv
src/soc_bus_top.sv
tb/soc_bus_tb.sv

/* Makefile */
SIM     = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = soc_bus_tb
FLIST   = soc_bus_top.f

OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
SRCS    = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

/* tb/soc_bus_tb.sv */
`timescale 1ns/1ps

module soc_bus_tb
	import soc_pkg::*;
();

	localparam int SCR_WORDS  = 8;
	localparam int SCR_MASKED = 16;	// byte-select writes on top of full words
	localparam int LED_ROUNDS = 4;
	localparam int IN_ROUNDS  = 4;
	localparam int RNG_READS  = 6;
	localparam int N_ACC = 2*SCR_WORDS + SCR_MASKED + 2*LED_ROUNDS + IN_ROUNDS + RNG_READS + 5;
	localparam int MAX_WAIT = 16;	// cycles from strobe to ack_o
	localparam int RUN_NS = (N_ACC * MAX_WAIT + 8 + 200) * 4;

	logic              cpu_clk;
	logic              rst_n_i;
	logic              cyc_i;
	logic              stb_i;
	logic              we_i;
	logic [SEL_W-1:0]  sel_i;
	logic [ADR_W-1:0]  adr_i;
	logic [DATA_W-1:0] dat_i;
	logic              ack_o;
	logic [DATA_W-1:0] dat_o;
	logic [7:0]        sw_i;
	logic [4:0]        btn_i;
	logic [7:0]        led_o;

	logic [31:0]       stim;	// stimulus lfsr state
	logic [31:0]       rng_exp;
	logic [DATA_W-1:0] scr_model [SCR_DEPTH];
	int                errors;
	int                checks;
	int                tests;
	int                err_mark;
	int                wait_cnt;
	int                drop_cnt;

	soc_bus_top dut0 (.*);

	initial cpu_clk = 1'b0;
	always #2 cpu_clk = ~cpu_clk;

	// --------------------------------------------------
	// stimulus source and reference models
	// --------------------------------------------------
	function automatic logic [31:0] stim_step(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'hA300_0000 : s >> 1;
	endfunction

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], stim[0]};
			stim = stim_step(stim);	// one step per bit
		end
		return r;
	endfunction

	// right shift with the taps folded in when a one leaves
	function automatic logic [31:0] rng_model_step(logic [31:0] s);
		logic [31:0] t;
		t = s >> 1;
		if (s[0])
			t = t ^ RNG_TAPS;
		return t;
	endfunction

	function automatic logic [31:0] scr_adr(logic [7:0] i);
		return {SCR_REGION, 11'd0, i, 3'd0};
	endfunction

	task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
		checks++;
		a_value: assert (got === exp) else begin
			$display("ERR %s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic test_done(string name);
		tests++;
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// one request held until ack_o and then released until ack_o drops
	task automatic bus_access(input logic we, input logic [7:0] sel, input logic [31:0] adr,
			input logic [63:0] wdat, output logic [63:0] rdat);
		int n;
		@(negedge cpu_clk);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		sel_i = sel;
		adr_i = adr;
		dat_i = wdat;
		n = 0;
		do begin
			@(negedge cpu_clk);
			n++;
		end while (!ack_o && n < MAX_WAIT + 4);
		rdat  = dat_o;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		n = 0;
		while (ack_o && n < 8) begin
			@(negedge cpu_clk);
			n++;
		end
	endtask

	task automatic rng_reads(int n);
		logic [63:0] rd;
		for (int k = 0; k < n; k++) begin
			bus_access(1'b0, 8'hFF, {IO_REGION, RNG_PAGE, 8'h00}, '0, rd);
			check_val("dat_o", {2{rng_exp}}, rd);	// replicated in both lanes
			rng_exp = rng_model_step(rng_exp);
		end
	endtask

	// --------------------------------------------------
	// handshake watch
	// --------------------------------------------------
	always @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			wait_cnt <= 0;
			drop_cnt <= 0;
		end else begin
			wait_cnt <= (stb_i && !ack_o) ? wait_cnt + 1 : 0;
			drop_cnt <= (!stb_i && ack_o) ? drop_cnt + 1 : 0;
		end
	end

	a_ack_in_time: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		wait_cnt <= MAX_WAIT) else begin
		$display("ack_o did not arrive within %0d cycles of the strobe", MAX_WAIT);
		errors++;
	end

	a_ack_falls: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		drop_cnt <= 3) else begin
		$display("ack_o stayed high after the strobe was dropped");
		errors++;
	end

	a_ack_has_req: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		ack_o |-> $past(cyc_i)) else begin
		$display("ack_o rose with no request on the bus");
		errors++;
	end

	initial begin
		#(RUN_NS);
		$display("watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		bus_word_u   w;
		bus_word_u   m;
		bus_word_u   e;
		logic [63:0] rd;
		logic [7:0]  idx [SCR_WORDS];
		logic [7:0]  sel;
		logic [7:0]  led_exp;
		logic [31:0] seed;
		logic [1:0]  b;
		logic        lane;
		int          j;
		rst_n_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		sw_i  = '0;
		btn_i = '0;
		stim  = 32'd50;
		rng_exp = RNG_RESET_SEED;
		led_exp = 8'h00;
		errors = 0;
		checks = 0;
		tests = 0;
		err_mark = 0;
		repeat (8) @(negedge cpu_clk);
		rst_n_i = 1'b1;
		repeat (4) @(negedge cpu_clk);
		check_val("ack_o", 64'd0, 64'(ack_o));
		check_val("led_o", 64'd0, 64'(led_o));
		test_done("reset");

		for (int k = 0; k < SCR_WORDS; k++) begin
			idx[k] = 8'(rand_bits(8));
			w = rand_bits(64);
			bus_access(1'b1, 8'hFF, scr_adr(idx[k]), w, rd);
			scr_model[idx[k]] = w;
		end
		for (int k = 0; k < SCR_MASKED; k++) begin
			j = int'(rand_bits(3));
			sel = 8'(rand_bits(8));
			w = rand_bits(64);
			bus_access(1'b1, sel, scr_adr(idx[j]), w, rd);
			m = scr_model[idx[j]];
			for (int i = 0; i < SEL_W; i++) begin
				if (sel[i])
					m.byte8[i] = w.byte8[i];	// unselected bytes keep old value
			end
			scr_model[idx[j]] = m;
		end
		for (int k = 0; k < SCR_WORDS; k++) begin
			bus_access(1'b0, 8'hFF, scr_adr(idx[k]), '0, rd);
			check_val("dat_o", scr_model[idx[k]], rd);
		end
		test_done("scratchpad");

		for (int k = 0; k < LED_ROUNDS; k++) begin
			b = 2'(rand_bits(2));	// byte lane through adr[1:0]
			sel = 8'(rand_bits(8));
			w = rand_bits(64);
			bus_access(1'b1, sel, {IO_REGION, GPIO_PAGE, GPIO_LED_OFS, b}, w, rd);
			if (sel[b])
				led_exp = w.byte8[b];
			check_val("led_o", 64'(led_exp), 64'(led_o));
			bus_access(1'b0, 8'hFF, {IO_REGION, GPIO_PAGE, GPIO_LED_OFS, 2'b00}, '0, rd);
			e.lane32[0] = {24'd0, led_exp};
			e.lane32[1] = e.lane32[0];
			check_val("dat_o", e, rd);
		end
		test_done("led");

		for (int k = 0; k < IN_ROUNDS; k++) begin
			sw_i  = 8'(rand_bits(8));
			btn_i = 5'(rand_bits(5));
			bus_access(1'b0, 8'hFF, {IO_REGION, GPIO_PAGE, GPIO_IN_OFS, 2'b00}, '0, rd);
			e = '0;
			e.lane32[0][20:16] = btn_i;	// c u d l r
			e.lane32[0][7:0]   = sw_i;
			e.lane32[1] = e.lane32[0];
			check_val("dat_o", e, rd);
		end
		test_done("inputs");

		lane = 1'(rand_bits(1));
		seed = 32'(rand_bits(32));
		w = rand_bits(64);
		w.lane32[lane] = seed;	// seed goes in the lane picked by adr[2]
		bus_access(1'b1, 8'hFF, {IO_REGION, RNG_PAGE, 5'd0, lane, 2'b00}, w, rd);
		rng_exp = (seed == 32'd0) ? RNG_RESET_SEED : seed;
		rng_reads(RNG_READS);
		w = rand_bits(64);
		w.lane32[0] = 32'd0;
		bus_access(1'b1, 8'hFF, {IO_REGION, RNG_PAGE, 8'h00}, w, rd);
		rng_exp = RNG_RESET_SEED;
		rng_reads(3);
		test_done("rng");

		repeat (20) @(negedge cpu_clk);
		check_val("ack_o", 64'd0, 64'(ack_o));
		test_done("handshake");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [SEL_W-1:0]  sel_i,
	input  logic [ADR_W-1:0]  adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o,
	input  logic [7:0]        sw_i,
	input  logic [4:0]        btn_i,
	output logic [7:0]        led_o
);

	logic              scr_cs;
	logic              io_cs;
	logic              scr_ack;
	logic              io_ack;
	logic [DATA_W-1:0] scr_dat;
	logic [DATA_W-1:0] io_dat;

	bus_fabric u_fabric (
		.cpu_clk   (cpu_clk),
		.rst_n_i   (rst_n_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.adr_i     (adr_i),
		.ack_o     (ack_o),
		.dat_o     (dat_o),
		.scr_cs_o  (scr_cs),
		.io_cs_o   (io_cs),
		.scr_ack_i (scr_ack),
		.io_ack_i  (io_ack),
		.scr_dat_i (scr_dat),
		.io_dat_i  (io_dat)
	);

	scratch_ram u_scr (
		.cpu_clk (cpu_clk),
		.rst_n_i (rst_n_i),
		.cs_i    (scr_cs),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.sel_i   (sel_i),
		.adr_i   (adr_i[SCR_AW+2:3]),	// word index
		.dat_i   (dat_i),
		.ack_o   (scr_ack),
		.dat_o   (scr_dat)
	);

	io_bridge u_iobr (
		.cpu_clk (cpu_clk),
		.rst_n_i (rst_n_i),
		.cs_i    (io_cs),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.sel_i   (sel_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.ack_o   (io_ack),
		.dat_o   (io_dat),
		.sw_i    (sw_i),
		.btn_i   (btn_i),
		.led_o   (led_o)
	);

endmodule

/* src/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic [ADR_W-1:0]  adr_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o,
	output logic              scr_cs_o,
	output logic              io_cs_o,
	input  logic              scr_ack_i,
	input  logic              io_ack_i,
	input  logic [DATA_W-1:0] scr_dat_i,
	input  logic [DATA_W-1:0] io_dat_i
);

	logic ack_any;	// target acks, live strobe only
	logic ack_seen;	// ack_any one cycle back

	// --------------------------------------------------
	// region decode
	// --------------------------------------------------
	assign scr_cs_o = adr_i[31:22] == SCR_REGION;
	// page within the region is left to the bridge
	assign io_cs_o  = adr_i[31:20] == IO_REGION;

	// --------------------------------------------------
	// ack filter
	// --------------------------------------------------
	// a stale target ack must not leak into the next access
	assign ack_any = (scr_ack_i | io_ack_i) & cyc_i & stb_i;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			ack_seen <= 1'b0;
			ack_o    <= 1'b0;
		end else begin
			ack_seen <= ack_any;
			ack_o    <= ack_seen & ack_any;	// two samples in a row
		end
	end

	// read word, scratchpad wins
	always_ff @(posedge cpu_clk) begin
		if (scr_cs_o)
			dat_o <= scr_dat_i;
		else if (io_cs_o)
			dat_o <= io_dat_i;
	end

	a_one_region: assert property (@(posedge cpu_clk) !(scr_cs_o && io_cs_o));

	// no ack once the master has left the bus
	a_no_idle_ack: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		!cyc_i ##1 !cyc_i |=> !ack_o);

endmodule

/* src/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [SEL_W-1:0]  sel_i,
	input  logic [SCR_AW-1:0] adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o
);

	logic [SEL_W-1:0][7:0] mem [SCR_DEPTH];
	logic                  req;

	assign req = cs_i & cyc_i & stb_i;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req;	// level ack that drops after the strobe
	end

	// byte lanes written only where selected
	always_ff @(posedge cpu_clk) begin
		if (req && we_i) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (sel_i[i])
					mem[adr_i][i] <= dat_i[i*8 +: 8];
			end
		end
		dat_o <= mem[adr_i];
	end

	a_ack_selected: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		ack_o |-> cs_i);

endmodule

/* src/io_bridge.sv */
`timescale 1ns/1ps

module io_bridge
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [SEL_W-1:0]  sel_i,
	input  logic [ADR_W-1:0]  adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o,
	input  logic [7:0]        sw_i,
	input  logic [4:0]        btn_i,
	output logic [7:0]        led_o
);

	// registered request, peripheral side
	logic              per_stb;
	logic              per_we;
	logic [SEL_W-1:0]  per_sel;
	logic [19:0]       per_adr;	// region bits already checked upstream
	bus_word_u         per_word;

	logic              gpio_cs;
	logic              rng_cs;
	logic [5:0]        per_ofs;
	logic [LANE_W-1:0] per_dat;
	logic [7:0]        per_dat8;
	logic              per_bsel;

	logic              gpio_ack;
	logic              rng_ack;
	logic [LANE_W-1:0] gpio_dat;
	logic [LANE_W-1:0] rng_dat;
	logic              per_ack;
	logic              per_ack_q;
	logic              per_ack_f;

	// --------------------------------------------------
	// request stage
	// --------------------------------------------------
	always_ff @(posedge cpu_clk) begin
		per_we   <= we_i;
		per_sel  <= sel_i;
		per_adr  <= adr_i[19:0];
		per_word <= dat_i;
	end

	assign gpio_cs  = per_stb && per_adr[19:8] == GPIO_PAGE;
	assign rng_cs   = per_stb && per_adr[19:8] == RNG_PAGE;
	assign per_ofs  = per_adr[7:2];
	assign per_dat  = per_word.lane32[per_adr[2]];	// 32-bit lane by adr[2]
	assign per_dat8 = per_word.byte8[per_adr[2:0]];
	assign per_bsel = per_sel[per_adr[2:0]];

	// --------------------------------------------------
	// ack filter and return path
	// --------------------------------------------------
	assign per_ack = (gpio_ack | rng_ack) & per_stb;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			per_stb   <= 1'b0;
			per_ack_q <= 1'b0;
			per_ack_f <= 1'b0;
			ack_o     <= 1'b0;
		end else begin
			per_stb   <= cs_i & cyc_i & stb_i;
			per_ack_q <= per_ack;
			per_ack_f <= per_ack_q & per_ack;
			// per_stb keeps a filter left over from the last access quiet
			ack_o     <= per_ack_f & per_stb & cs_i & cyc_i & stb_i;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (gpio_cs)
			dat_o <= {2{gpio_dat}};	// same word in both lanes
		else if (rng_cs)
			dat_o <= {2{rng_dat}};
	end

	gpio_regs u_gpio (
		.cpu_clk    (cpu_clk),
		.rst_n_i    (rst_n_i),
		.cs_i       (gpio_cs),
		.stb_i      (per_stb),
		.we_i       (per_we),
		.ofs_i      (per_ofs),
		.byte_sel_i (per_bsel),
		.dat8_i     (per_dat8),
		.sw_i       (sw_i),
		.btn_i      (btn_i),
		.ack_o      (gpio_ack),
		.dat_o      (gpio_dat),
		.led_o      (led_o)
	);

	rng_gen u_rng (
		.cpu_clk (cpu_clk),
		.rst_n_i (rst_n_i),
		.cs_i    (rng_cs),
		.stb_i   (per_stb),
		.we_i    (per_we),
		.dat_i   (per_dat),
		.ack_o   (rng_ack),
		.dat_o   (rng_dat)
	);

	a_one_per_ack: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		!(gpio_ack && rng_ack));

endmodule

/* src/rng_gen.sv */
`timescale 1ns/1ps

module rng_gen
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [LANE_W-1:0] dat_i,
	output logic              ack_o,
	output logic [LANE_W-1:0] dat_o
);

	logic [LANE_W-1:0] state;
	logic [LANE_W-1:0] state_nxt;
	logic              rd_pend;	// strobe in progress is a read

	// shift right, fold the taps in when a one drops out
	assign state_nxt = state[0] ? (state >> 1) ^ RNG_TAPS : state >> 1;
	assign dat_o = state;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			state   <= RNG_RESET_SEED;
			rd_pend <= 1'b0;
			ack_o   <= 1'b0;
		end else begin
			ack_o <= cs_i & stb_i;
			if (cs_i && stb_i) begin
				rd_pend <= !we_i;
				if (we_i)
					state <= (dat_i == '0) ? RNG_RESET_SEED : dat_i;	// zero would lock up
			end else if (ack_o && rd_pend) begin
				state   <= state_nxt;	// one step per finished read
				rd_pend <= 1'b0;
			end
		end
	end

	a_state_live: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		state != '0);

endmodule

/* src/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs
	import soc_pkg::*;
(
	input  logic              cpu_clk,
	input  logic              rst_n_i,
	input  logic              cs_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  logic [5:0]        ofs_i,
	input  logic              byte_sel_i,
	input  logic [7:0]        dat8_i,
	input  logic [7:0]        sw_i,
	input  logic [4:0]        btn_i,	// c u d l r, msb first
	output logic              ack_o,
	output logic [LANE_W-1:0] dat_o,
	output logic [7:0]        led_o
);

	logic [LANE_W-1:0] in_port;

	// buttons at 20..16, switches at 7..0
	assign in_port = {11'h000, btn_i, 8'h00, sw_i};

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			led_o <= 8'h00;
		end else begin
			ack_o <= cs_i & stb_i;
			if (cs_i && stb_i && we_i && byte_sel_i && ofs_i == GPIO_LED_OFS)
				led_o <= dat8_i;
		end
	end

	always_comb begin
		case (ofs_i)
			GPIO_LED_OFS: dat_o = {24'h000000, led_o};
			GPIO_IN_OFS:  dat_o = in_port;
			default:      dat_o = '0;	// unused offsets read zero
		endcase
	end

endmodule

/* src/soc_pkg.sv */
package soc_pkg;

	// --------------------------------------------------
	// cpu bus widths
	// --------------------------------------------------
	localparam int DATA_W = 64;	// one bus word
	localparam int ADR_W  = 32;
	localparam int SEL_W  = DATA_W / 8;	// byte selects
	localparam int LANE_W = 32;	// narrow peripheral word

	// --------------------------------------------------
	// address map
	// --------------------------------------------------
	// scratchpad lives where adr[31:22] matches
	localparam logic [9:0] SCR_REGION = 10'b1111111101;
	localparam int SCR_DEPTH = 256;	// 64-bit words
	localparam int SCR_AW    = $clog2(SCR_DEPTH);

	// i/o space is FFDxxxxx, pages are adr[19:8]
	localparam logic [11:0] IO_REGION = 12'hFFD;
	localparam logic [11:0] GPIO_PAGE = 12'hC06;	// leds, switches, buttons
	localparam logic [11:0] RNG_PAGE  = 12'hC0C;

	// gpio register offsets, adr[7:2]
	localparam logic [5:0] GPIO_LED_OFS = 6'd0;
	localparam logic [5:0] GPIO_IN_OFS  = 6'd1;

	// --------------------------------------------------
	// random generator
	// --------------------------------------------------
	localparam logic [LANE_W-1:0] RNG_TAPS       = 32'hB4BCD35C;	// galois mask
	localparam logic [LANE_W-1:0] RNG_RESET_SEED = 32'h0000_0001;

	// one bus word seen as two 32-bit lanes or as eight bytes
	// lane and byte 0 sit at the low end, same as the address order
	typedef union packed {
		logic [1:0][LANE_W-1:0] lane32;
		logic [SEL_W-1:0][7:0]  byte8;
	} bus_word_u;

endpackage
